/* build.f */
hdl/al_accel_pkg.sv
hdl/al_accel_config_regs.sv
hdl/al_accel_fetch.sv
hdl/al_accel_dot_unit.sv
hdl/al_accel_requant.sv
hdl/al_accel_writeback.sv
hdl/al_accel_mem_arbiter.sv
hdl/al_accel_top.sv
testbench/al_accel_assert.sv
testbench/tb_al_accel.sv

/* Makefile */
# An aborted simulation also counts as a failure in the log

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_al_accel -Mdir obj_dir
	./obj_dir/Vtb_al_accel > sim.log 2>&1 || echo ">>> FAIL" >> sim.log
	cat sim.log
	! grep -q ">>> FAIL" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* testbench/tb_al_accel.sv */
`timescale 1ns/1ns

module tb_al_accel;

    localparam int MEM_BYTES  = 4096;
    // Each job takes a few hundred cycles at most
    localparam int MAX_CYCLES = 20000;

    logic                               clk;
    logic                               i_rst;
    logic                               i_cfg_valid;
    logic [al_accel_pkg::CFG_SEL_W-1:0] i_cfg_sel;
    al_accel_pkg::cfg_word_u            i_cfg_data;
    logic                               i_start;
    logic                               o_busy;
    logic                               o_done;
    al_accel_pkg::mem_req_t             o_mem_req;
    logic                               o_mem_valid;
    logic                               i_mem_ready;
    logic [al_accel_pkg::DATA_W-1:0]    i_mem_rdata;
    logic                               i_mem_rvalid;

    logic [7:0]                 mem [MEM_BYTES];
    al_accel_pkg::mem_req_t     exp_q [$];
    al_accel_pkg::layer_cfg_t   job;
    int                         rd_wait;
    logic [31:0]                rd_word;
    int                         job_writes;
    int                         job_outputs;
    int                         done_cnt;
    int                         cycles = 0;
    int unsigned                seed;

    al_accel_top i_dut (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_sel    (i_cfg_sel),
        .i_cfg_data   (i_cfg_data),
        .i_start      (i_start),
        .o_busy       (o_busy),
        .o_done       (o_done),
        .o_mem_req    (o_mem_req),
        .o_mem_valid  (o_mem_valid),
        .i_mem_ready  (i_mem_ready),
        .i_mem_rdata  (i_mem_rdata),
        .i_mem_rvalid (i_mem_rvalid)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            stop_run($sformatf("Timeout, run still going after %0d cycles", MAX_CYCLES));
        end
    end

    // Byte k of a word sits at addr + k
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        int a;
        a = int'({addr[11:2], 2'b00});
        return {mem[a+3], mem[a+2], mem[a+1], mem[a]};
    endfunction

    task automatic set_word(input logic [31:0] addr, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            mem[int'({addr[11:2], 2'b00}) + b] = data[8*b +: 8];
        end
    endtask

    function automatic logic [7:0] requant_ref(input int acc, input al_accel_pkg::layer_cfg_t cfg);
        longint v;
        v = longint'(acc) * longint'(int'(cfg.mult));
        v = v >>> cfg.shift;
        if (cfg.layer.act == al_accel_pkg::ACT_RELU && v < 0) begin
            v = 0;
        end
        v = v + longint'(int'(cfg.out_ofs));
        if (v > 127) begin
            return 8'h7f;
        end
        if (v < -128) begin
            return 8'h80;
        end
        return 8'(v);
    endfunction

    // Fresh operands and the expected write for every output
    task automatic load_job(input al_accel_pkg::layer_cfg_t cfg);
        int                     acc;
        int                     nin;
        byte                    x;
        byte                    w;
        logic [31:0]            act_w;
        logic [31:0]            wgt_w;
        logic [31:0]            o_addr;
        logic [7:0]             q;
        al_accel_pkg::mem_req_t req;
        nin = int'(cfg.layer.in_words);
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem[i] = 8'($urandom());
        end
        // Small biases keep some results inside int8
        for (int j = 0; j < int'(cfg.layer.out_num); j++) begin
            set_word(cfg.b_base + 32'(4 * j), 32'($urandom_range(0, 4000)) - 32'd2000);
        end
        for (int j = 0; j < int'(cfg.layer.out_num); j++) begin
            acc = int'(word_at(cfg.b_base + 32'(4 * j)));
            for (int i = 0; i < nin; i++) begin
                act_w = word_at(cfg.in_base + 32'(4 * i));
                wgt_w = word_at(cfg.w_base + 32'(4 * (j * nin + i)));
                for (int l = 0; l < al_accel_pkg::LANES; l++) begin
                    x   = byte'(act_w[8*l +: 8]);
                    w   = byte'(wgt_w[8*l +: 8]);
                    acc = acc + (int'(x) + int'(cfg.in_ofs)) * int'(w);
                end
            end
            q         = requant_ref(acc, cfg);
            o_addr    = cfg.o_base + 32'(j);
            req.wr    = 1'b1;
            req.addr  = {o_addr[31:2], 2'b00};
            req.wdata = {4{q}};
            req.strb  = 4'b0001 << o_addr[1:0];
            exp_q.push_back(req);
        end
        job_outputs = int'(cfg.layer.out_num);
    endtask

    task automatic write_reg(input logic [3:0] sel, input logic [31:0] data);
        @(posedge clk);
        i_cfg_valid     <= 1'b1;
        i_cfg_sel       <= sel;
        i_cfg_data.raw  <= data;
    endtask

    task automatic write_config(input al_accel_pkg::layer_cfg_t cfg);
        write_reg(al_accel_pkg::CFG_LAYER, cfg.layer);
        write_reg(al_accel_pkg::CFG_IN_BASE, cfg.in_base);
        write_reg(al_accel_pkg::CFG_W_BASE, cfg.w_base);
        write_reg(al_accel_pkg::CFG_B_BASE, cfg.b_base);
        write_reg(al_accel_pkg::CFG_O_BASE, cfg.o_base);
        write_reg(al_accel_pkg::CFG_MULT, cfg.mult);
        write_reg(al_accel_pkg::CFG_SHIFT, 32'(cfg.shift));
        write_reg(al_accel_pkg::CFG_IN_OFS, cfg.in_ofs);
        write_reg(al_accel_pkg::CFG_OUT_OFS, cfg.out_ofs);
        @(posedge clk);
        i_cfg_valid <= 1'b0;
    endtask

    // Memory model serviced once per rising edge
    task automatic service_bus();
        al_accel_pkg::mem_req_t exp;
        i_mem_rvalid <= 1'b0;
        if (rd_wait > 0) begin
            if (rd_wait == 1) begin
                i_mem_rvalid <= 1'b1;
                i_mem_rdata  <= rd_word;
            end
            rd_wait = rd_wait - 1;
        end
        if (o_mem_valid && i_mem_ready) begin
            if (o_mem_req.wr) begin
                assert (exp_q.size() > 0) else stop_run("Write issued with no output expected");
                exp = exp_q.pop_front();
                assert (o_mem_req == exp) else stop_run($sformatf(
                    "ERR %0t o_mem_req expected %h got %h", $time, exp, o_mem_req));
                for (int b = 0; b < 4; b++) begin
                    if (o_mem_req.strb[b]) begin
                        mem[int'(o_mem_req.addr[11:0]) + b] = o_mem_req.wdata[8*b +: 8];
                    end
                end
                job_writes++;
            end else begin
                rd_word = word_at(o_mem_req.addr);
                rd_wait = $urandom_range(1, 3);
            end
        end
        if (o_done) begin
            assert (job_writes == job_outputs) else stop_run($sformatf(
                "ERR %0t job_writes expected %0d got %0d", $time, job_outputs, job_writes));
            done_cnt++;
            job_writes = 0;
        end
        i_mem_ready <= ($urandom_range(0, 3) != 0);
    endtask

    task automatic run_job(input al_accel_pkg::layer_cfg_t cfg);
        int done_before;
        done_before = done_cnt;
        load_job(cfg);
        write_config(cfg);
        @(posedge clk);
        i_start <= 1'b1;
        @(posedge clk);
        i_start <= 1'b0;
        @(negedge clk);
        assert (o_busy) else stop_run("o_busy did not rise after i_start");
        // Start held after the first write must be ignored
        while (done_cnt == done_before) begin
            @(posedge clk);
            service_bus();
            i_start <= (job_writes == 1);
        end
        repeat (5) begin
            @(posedge clk);
            service_bus();
        end
        assert (done_cnt == done_before + 1 && !o_busy)
            else stop_run("o_done pulsed again or o_busy stayed high after the job");
    endtask

    initial begin
        seed         = $urandom(32'ha3f99548);
        clk          = 1'b0;
        i_rst        = 1'b1;
        i_cfg_valid  = 1'b0;
        i_cfg_sel    = '0;
        i_cfg_data   = '0;
        i_start      = 1'b0;
        i_mem_ready  = 1'b0;
        i_mem_rdata  = '0;
        i_mem_rvalid = 1'b0;
        rd_wait      = 0;
        rd_word      = '0;
        job_writes   = 0;
        job_outputs  = 0;
        done_cnt     = 0;
        repeat (4) @(posedge clk);
        i_rst <= 1'b0;

        // Plain dense layer with an unaligned output base
        job = '{layer: '{act: al_accel_pkg::ACT_NONE, in_words: 12'd3, out_num: 16'd6},
                in_base: 32'h100, w_base: 32'h200, b_base: 32'h600, o_base: 32'h801,
                mult: 32'h0010_0000, shift: 6'd30, in_ofs: 32'd3, out_ofs: -32'sd5};
        run_job(job);

        // ReLU with a large multiplier
        job = '{layer: '{act: al_accel_pkg::ACT_RELU, in_words: 12'd2, out_num: 16'd8},
                in_base: 32'h140, w_base: 32'h300, b_base: 32'h680, o_base: 32'ha02,
                mult: 32'h7fff_0000, shift: 6'd28, in_ofs: 32'd0, out_ofs: -32'sd7};
        run_job(job);

        // Saturation both ways from a single input word
        job = '{layer: '{act: al_accel_pkg::ACT_NONE, in_words: 12'd1, out_num: 16'd5},
                in_base: 32'h180, w_base: 32'h400, b_base: 32'h700, o_base: 32'hc00,
                mult: 32'h4000_0000, shift: 6'd24, in_ofs: 32'd128, out_ofs: 32'd1};
        run_job(job);

        $display(">>> PASS");
        $finish;
    end

endmodule

/* testbench/al_accel_assert.sv */
`timescale 1ns/1ns

module al_accel_assert (
    input logic                   clk,
    input logic                   i_rst,
    input al_accel_pkg::mem_req_t o_mem_req,
    input logic                   o_mem_valid,
    input logic                   i_mem_ready,
    input logic                   o_busy,
    input logic                   o_done
);

    // Request held while the bus stalls
    property p_req_stable;
        @(posedge clk) disable iff (i_rst)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req);
    endproperty

    property p_done_pulse;
        @(posedge clk) disable iff (i_rst)
        o_done |=> !o_done;
    endproperty

    // Busy falls in the done cycle
    property p_done_busy;
        @(posedge clk) disable iff (i_rst)
        o_done |-> !o_busy && $past(o_busy);
    endproperty

    property p_reset_quiet;
        @(posedge clk)
        i_rst |=> !o_mem_valid && !o_busy && !o_done;
    endproperty

    a_req_stable:  assert property (p_req_stable) else $error("memory request changed in stall");
    a_done_pulse:  assert property (p_done_pulse) else $error("o_done longer than one cycle");
    a_done_busy:   assert property (p_done_busy) else $error("o_done not aligned with busy fall");
    a_reset_quiet: assert property (p_reset_quiet) else $error("outputs active during reset");

endmodule

bind al_accel_top al_accel_assert u_assert (
    .clk         (clk),
    .i_rst       (i_rst),
    .o_mem_req   (o_mem_req),
    .o_mem_valid (o_mem_valid),
    .i_mem_ready (i_mem_ready),
    .o_busy      (o_busy),
    .o_done      (o_done)
);

/* hdl/al_accel_top.sv */
`timescale 1ns/1ns

module al_accel_top (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                i_cfg_valid,
    input  logic [al_accel_pkg::CFG_SEL_W-1:0]  i_cfg_sel,
    input  al_accel_pkg::cfg_word_u             i_cfg_data,
    input  logic                                i_start,
    output logic                                o_busy,
    output logic                                o_done,
    output al_accel_pkg::mem_req_t              o_mem_req,
    output logic                                o_mem_valid,
    input  logic                                i_mem_ready,
    input  logic [al_accel_pkg::DATA_W-1:0]     i_mem_rdata,
    input  logic                                i_mem_rvalid
);

    al_accel_pkg::layer_cfg_t        cfg;
    al_accel_pkg::mem_req_t          fe_req;
    al_accel_pkg::mem_req_t          wb_req;
    logic                            fe_valid;
    logic                            fe_ready;
    logic                            wb_valid;
    logic                            wb_ready;
    al_accel_pkg::mac_beat_t         beat;
    logic                            beat_valid;
    logic                            beat_ready;
    logic [al_accel_pkg::DATA_W-1:0] acc;
    logic                            acc_valid;
    logic                            acc_ready;
    logic [7:0]                      q;
    logic                            q_valid;
    logic                            q_ready;

    al_accel_config_regs u_cfg (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_cfg_valid (i_cfg_valid),
        .i_cfg_sel   (i_cfg_sel),
        .i_cfg_data  (i_cfg_data),
        .o_cfg       (cfg)
    );

    // Start only counts while idle
    al_accel_fetch u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_start      (i_start && !o_busy),
        .i_cfg        (cfg),
        .o_req        (fe_req),
        .o_req_valid  (fe_valid),
        .i_req_ready  (fe_ready),
        .i_rdata      (i_mem_rdata),
        .i_rvalid     (i_mem_rvalid),
        .o_beat       (beat),
        .o_beat_valid (beat_valid),
        .i_beat_ready (beat_ready)
    );

    al_accel_dot_unit u_dot (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_cfg        (cfg),
        .i_beat       (beat),
        .i_beat_valid (beat_valid),
        .o_beat_ready (beat_ready),
        .o_acc        (acc),
        .o_acc_valid  (acc_valid),
        .i_acc_ready  (acc_ready)
    );

    al_accel_requant u_requant (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_cfg       (cfg),
        .i_acc       (acc),
        .i_acc_valid (acc_valid),
        .o_acc_ready (acc_ready),
        .o_q         (q),
        .o_q_valid   (q_valid),
        .i_q_ready   (q_ready)
    );

    al_accel_writeback u_wb (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_start     (i_start),
        .i_cfg       (cfg),
        .i_q         (q),
        .i_q_valid   (q_valid),
        .o_q_ready   (q_ready),
        .o_req       (wb_req),
        .o_req_valid (wb_valid),
        .i_req_ready (wb_ready),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    al_accel_mem_arbiter u_arb (
        .clk         (clk),
        .i_rst       (i_rst),
        .i_wb_req    (wb_req),
        .i_wb_valid  (wb_valid),
        .o_wb_ready  (wb_ready),
        .i_fe_req    (fe_req),
        .i_fe_valid  (fe_valid),
        .o_fe_ready  (fe_ready),
        .o_mem_req   (o_mem_req),
        .o_mem_valid (o_mem_valid),
        .i_mem_ready (i_mem_ready)
    );

endmodule

/* hdl/al_accel_mem_arbiter.sv */
`timescale 1ns/1ns

module al_accel_mem_arbiter (
    input  logic                   clk,
    input  logic                   i_rst,
    input  al_accel_pkg::mem_req_t i_wb_req,
    input  logic                   i_wb_valid,
    output logic                   o_wb_ready,
    input  al_accel_pkg::mem_req_t i_fe_req,
    input  logic                   i_fe_valid,
    output logic                   o_fe_ready,
    output al_accel_pkg::mem_req_t o_mem_req,
    output logic                   o_mem_valid,
    input  logic                   i_mem_ready
);

    logic lock_q;
    logic lock_wb_q;
    logic sel_wb;

    // Writeback first, held while the bus stalls
    assign sel_wb      = lock_q ? lock_wb_q : i_wb_valid;
    assign o_mem_req   = sel_wb ? i_wb_req : i_fe_req;
    assign o_mem_valid = sel_wb ? i_wb_valid : i_fe_valid;
    assign o_wb_ready  = sel_wb && i_mem_ready;
    assign o_fe_ready  = !sel_wb && i_mem_ready;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            lock_q    <= 1'b0;
            lock_wb_q <= 1'b0;
        end else begin
            lock_q    <= o_mem_valid && !i_mem_ready;
            lock_wb_q <= sel_wb;
        end
    end

endmodule

/* hdl/al_accel_writeback.sv */
`timescale 1ns/1ns

module al_accel_writeback (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_start,
    input  al_accel_pkg::layer_cfg_t i_cfg,
    input  logic [7:0]               i_q,
    input  logic                     i_q_valid,
    output logic                     o_q_ready,
    output al_accel_pkg::mem_req_t   o_req,
    output logic                     o_req_valid,
    input  logic                     i_req_ready,
    output logic                     o_busy,
    output logic                     o_done
);

    logic [15:0]                     out_cnt;
    logic [al_accel_pkg::ADDR_W-1:0] byte_addr;
    logic                            q_fire;
    logic                            req_fire;

    assign byte_addr = i_cfg.o_base + {{(al_accel_pkg::ADDR_W-16){1'b0}}, out_cnt};
    assign o_q_ready = o_busy && !o_req_valid;
    assign q_fire    = i_q_valid && o_q_ready;
    assign req_fire  = o_req_valid && i_req_ready;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
            o_req_valid <= 1'b0;
            out_cnt     <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start && !o_busy) begin
                o_busy  <= 1'b1;
                out_cnt <= '0;
            end
            if (q_fire) begin
                o_req_valid <= 1'b1;
            end else if (req_fire) begin
                o_req_valid <= 1'b0;
                out_cnt     <= out_cnt + 16'd1;
                // Last output accepted ends the job
                if (out_cnt == i_cfg.layer.out_num - 16'd1) begin
                    o_busy <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // Byte replicated, strobe picks the lane
    always_ff @(posedge clk) begin
        if (q_fire) begin
            o_req.wr    <= 1'b1;
            o_req.addr  <= {byte_addr[al_accel_pkg::ADDR_W-1:2], 2'b00};
            o_req.wdata <= {al_accel_pkg::LANES{i_q}};
            o_req.strb  <= {{(al_accel_pkg::LANES-1){1'b0}}, 1'b1} << byte_addr[1:0];
        end
    end

endmodule

/* hdl/al_accel_requant.sv */
`timescale 1ns/1ns

module al_accel_requant (
    input  logic                              clk,
    input  logic                              i_rst,
    input  al_accel_pkg::layer_cfg_t          i_cfg,
    input  logic [al_accel_pkg::DATA_W-1:0]   i_acc,
    input  logic                              i_acc_valid,
    output logic                              o_acc_ready,
    output logic [7:0]                        o_q,
    output logic                              o_q_valid,
    input  logic                              i_q_ready
);

    logic signed [63:0] prod;
    logic signed [63:0] shifted;
    logic signed [63:0] biased;
    logic [7:0]         q_next;
    logic               acc_fire;

    always_comb begin
        prod    = $signed(i_acc) * $signed(i_cfg.mult);
        shifted = prod >>> i_cfg.shift;
        if (i_cfg.layer.act == al_accel_pkg::ACT_RELU && shifted < 0) begin
            shifted = '0;
        end
        biased = shifted + $signed(i_cfg.out_ofs);
        // Saturate to int8
        if (biased > 64'sd127) begin
            q_next = 8'h7f;
        end else if (biased < -64'sd128) begin
            q_next = 8'h80;
        end else begin
            q_next = biased[7:0];
        end
    end

    assign o_acc_ready = !o_q_valid || i_q_ready;
    assign acc_fire    = i_acc_valid && o_acc_ready;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_q_valid <= 1'b0;
        end else if (acc_fire) begin
            o_q_valid <= 1'b1;
        end else if (i_q_ready) begin
            o_q_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc_fire) begin
            o_q <= q_next;
        end
    end

endmodule

/* hdl/al_accel_dot_unit.sv */
`timescale 1ns/1ns

module al_accel_dot_unit (
    input  logic                              clk,
    input  logic                              i_rst,
    input  al_accel_pkg::layer_cfg_t          i_cfg,
    input  al_accel_pkg::mac_beat_t           i_beat,
    input  logic                              i_beat_valid,
    output logic                              o_beat_ready,
    output logic [al_accel_pkg::DATA_W-1:0]   o_acc,
    output logic                              o_acc_valid,
    input  logic                              i_acc_ready
);

    logic signed [al_accel_pkg::DATA_W-1:0] lane_sum;
    logic                                   beat_fire;

    assign o_beat_ready = !o_acc_valid;
    assign beat_fire    = i_beat_valid && o_beat_ready;

    // Four int8 lanes, offset added to each activation
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < al_accel_pkg::LANES; l++) begin
            lane_sum = lane_sum
                + ($signed(i_beat.act[8*l +: 8]) + $signed(i_cfg.in_ofs))
                * $signed(i_beat.wgt[8*l +: 8]);
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_acc_valid <= 1'b0;
        end else if (beat_fire && i_beat.last) begin
            o_acc_valid <= 1'b1;
        end else if (i_acc_ready) begin
            o_acc_valid <= 1'b0;
        end
    end

    // Bias beat loads, others accumulate with wrap
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            o_acc <= i_beat.bias ? i_beat.act : o_acc + lane_sum;
        end
    end

endmodule

/* hdl/al_accel_fetch.sv */
`timescale 1ns/1ns

module al_accel_fetch (
    input  logic                              clk,
    input  logic                              i_rst,
    input  logic                              i_start,
    input  al_accel_pkg::layer_cfg_t          i_cfg,
    output al_accel_pkg::mem_req_t            o_req,
    output logic                              o_req_valid,
    input  logic                              i_req_ready,
    input  logic [al_accel_pkg::DATA_W-1:0]   i_rdata,
    input  logic                              i_rvalid,
    output al_accel_pkg::mac_beat_t           o_beat,
    output logic                              o_beat_valid,
    input  logic                              i_beat_ready
);

    typedef enum logic [2:0] {S_IDLE, S_BIAS, S_IN, S_WGT, S_BEAT} state_t;

    state_t                          state;
    logic                            pend;
    logic                            rd_done;
    logic [11:0]                     in_idx;
    logic [15:0]                     out_idx;
    logic [al_accel_pkg::ADDR_W-1:0] b_addr;
    logic [al_accel_pkg::ADDR_W-1:0] in_addr;
    logic [al_accel_pkg::ADDR_W-1:0] w_addr;
    logic                            last_in;
    logic                            last_out;

    assign last_in  = (in_idx == i_cfg.layer.in_words - 12'd1);
    assign last_out = (out_idx == i_cfg.layer.out_num - 16'd1);
    assign rd_done  = pend && i_rvalid;

    // Read only, one outstanding at a time
    always_comb begin
        o_req = '0;
        case (state)
            S_BIAS:  o_req.addr = b_addr;
            S_IN:    o_req.addr = in_addr;
            default: o_req.addr = w_addr;
        endcase
    end

    assign o_req_valid  = !pend && (state == S_BIAS || state == S_IN || state == S_WGT);
    assign o_beat_valid = (state == S_BEAT);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            state   <= S_IDLE;
            pend    <= 1'b0;
            in_idx  <= '0;
            out_idx <= '0;
            b_addr  <= '0;
            in_addr <= '0;
            w_addr  <= '0;
        end else begin
            if (o_req_valid && i_req_ready) begin
                pend <= 1'b1;
            end else if (i_rvalid) begin
                pend <= 1'b0;
            end

            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state   <= S_BIAS;
                        out_idx <= '0;
                        b_addr  <= i_cfg.b_base;
                        w_addr  <= i_cfg.w_base;
                    end
                end
                S_BIAS: begin
                    if (rd_done) begin
                        state  <= S_BEAT;
                        b_addr <= b_addr + 'd4;
                    end
                end
                S_IN: begin
                    if (rd_done) begin
                        state   <= S_WGT;
                        in_addr <= in_addr + 'd4;
                    end
                end
                S_WGT: begin
                    if (rd_done) begin
                        state  <= S_BEAT;
                        w_addr <= w_addr + 'd4;
                    end
                end
                S_BEAT: begin
                    if (i_beat_ready) begin
                        if (o_beat.bias) begin
                            state   <= S_IN;
                            in_idx  <= '0;
                            in_addr <= i_cfg.in_base;
                        end else if (!last_in) begin
                            state  <= S_IN;
                            in_idx <= in_idx + 12'd1;
                        end else begin
                            state   <= last_out ? S_IDLE : S_BIAS;
                            out_idx <= out_idx + 16'd1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Pair the input word with its weight word
    always_ff @(posedge clk) begin
        if (rd_done) begin
            case (state)
                S_BIAS: begin
                    o_beat.bias <= 1'b1;
                    o_beat.last <= 1'b0;
                    o_beat.act  <= i_rdata;
                    o_beat.wgt  <= '0;
                end
                S_IN: begin
                    o_beat.bias <= 1'b0;
                    o_beat.last <= last_in;
                    o_beat.act  <= i_rdata;
                end
                S_WGT:   o_beat.wgt <= i_rdata;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/al_accel_config_regs.sv */
`timescale 1ns/1ns

module al_accel_config_regs (
    input  logic                                clk,
    input  logic                                i_rst,
    input  logic                                i_cfg_valid,
    input  logic [al_accel_pkg::CFG_SEL_W-1:0]  i_cfg_sel,
    input  al_accel_pkg::cfg_word_u             i_cfg_data,
    output al_accel_pkg::layer_cfg_t            o_cfg
);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_cfg <= '0;
        end else if (i_cfg_valid) begin
            case (i_cfg_sel)
                al_accel_pkg::CFG_LAYER: begin
                    // Unknown activation codes fall back to none
                    if (i_cfg_data.layer.act == al_accel_pkg::ACT_RELU) begin
                        o_cfg.layer.act <= al_accel_pkg::ACT_RELU;
                    end else begin
                        o_cfg.layer.act <= al_accel_pkg::ACT_NONE;
                    end
                    o_cfg.layer.in_words <= i_cfg_data.layer.in_words;
                    o_cfg.layer.out_num  <= i_cfg_data.layer.out_num;
                end
                al_accel_pkg::CFG_IN_BASE: o_cfg.in_base <= i_cfg_data.raw;
                al_accel_pkg::CFG_W_BASE:  o_cfg.w_base  <= i_cfg_data.raw;
                al_accel_pkg::CFG_B_BASE:  o_cfg.b_base  <= i_cfg_data.raw;
                al_accel_pkg::CFG_O_BASE:  o_cfg.o_base  <= i_cfg_data.raw;
                al_accel_pkg::CFG_MULT:    o_cfg.mult    <= i_cfg_data.raw;
                al_accel_pkg::CFG_SHIFT:   o_cfg.shift   <= i_cfg_data.raw[5:0];
                al_accel_pkg::CFG_IN_OFS:  o_cfg.in_ofs  <= i_cfg_data.raw;
                al_accel_pkg::CFG_OUT_OFS: o_cfg.out_ofs <= i_cfg_data.raw;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/al_accel_pkg.sv */
package al_accel_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int LANES     = 4;
    localparam int CFG_SEL_W = 4;

    // Configuration register selects
    localparam logic [CFG_SEL_W-1:0] CFG_LAYER   = 4'd0;
    localparam logic [CFG_SEL_W-1:0] CFG_IN_BASE = 4'd1;
    localparam logic [CFG_SEL_W-1:0] CFG_W_BASE  = 4'd2;
    localparam logic [CFG_SEL_W-1:0] CFG_B_BASE  = 4'd3;
    localparam logic [CFG_SEL_W-1:0] CFG_O_BASE  = 4'd4;
    localparam logic [CFG_SEL_W-1:0] CFG_MULT    = 4'd5;
    localparam logic [CFG_SEL_W-1:0] CFG_SHIFT   = 4'd6;
    localparam logic [CFG_SEL_W-1:0] CFG_IN_OFS  = 4'd7;
    localparam logic [CFG_SEL_W-1:0] CFG_OUT_OFS = 4'd8;

    localparam logic [3:0] ACT_NONE = 4'd0;
    localparam logic [3:0] ACT_RELU = 4'd1;

    typedef struct packed {
        logic [3:0]  act;
        logic [11:0] in_words;
        logic [15:0] out_num;
    } layer_info_t;

    // Layer word seen either raw or as fields
    typedef union packed {
        logic [DATA_W-1:0] raw;
        layer_info_t       layer;
    } cfg_word_u;

    typedef struct packed {
        layer_info_t       layer;
        logic [ADDR_W-1:0] in_base;
        logic [ADDR_W-1:0] w_base;
        logic [ADDR_W-1:0] b_base;
        logic [ADDR_W-1:0] o_base;
        logic [DATA_W-1:0] mult;
        logic [5:0]        shift;
        logic [DATA_W-1:0] in_ofs;
        logic [DATA_W-1:0] out_ofs;
    } layer_cfg_t;

    typedef struct packed {
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [LANES-1:0]  strb;
    } mem_req_t;

    // In a bias beat the act word carries the bias
    typedef struct packed {
        logic              bias;
        logic              last;
        logic [DATA_W-1:0] act;
        logic [DATA_W-1:0] wgt;
    } mac_beat_t;

endpackage
